//--- rtl/data_memory.sv
// 16-word single-port data memory acting as the four-phase bus slave.
`timescale 1ns/100ps
`default_nettype none

module data_memory (
    input logic       clk,
    input logic       rst,
    mem_bus_if.slave  bus
);

    logic [mem_pkg::DATA_WIDTH-1:0]  mem [mem_pkg::MEM_WORDS];
    logic                            clearing;
    logic [mem_pkg::ADDR_WIDTH-1:0]  clear_addr;
    logic                            start;

    // New request seen, operation happens this cycle.
    assign start = bus.req && !bus.ack && !clearing;

    // Clear sweep and handshake control.
    // Requests wait until every word has been zeroed.
    always_ff @(posedge clk) begin
        if (rst) begin
            clearing   <= 1'b1;
            clear_addr <= '0;
            bus.ack    <= 1'b0;
        end else if (clearing) begin
            clear_addr <= clear_addr + 1'b1;
            if (clear_addr == '1) begin
                clearing <= 1'b0;
            end
        end else begin
            // Ack follows req one cycle late, both edges.
            bus.ack <= bus.req;
        end
    end

    // Single write port shared by the sweep and the bus.
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clear_addr] <= '0;
        end else if (start && bus.op == mem_pkg::op_write) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    // Read data lands together with ack.
    always_ff @(posedge clk) begin
        if (start && bus.op == mem_pkg::op_read) begin
            bus.rdata <= mem[bus.addr];
        end
    end

    // Master waits for ack low before a new request.
    a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(bus.req) |-> !bus.ack)
        else $error("data_memory saw req rise while ack was high");

endmodule

`default_nettype wire

//--- rtl/fifo_if.sv
// Request FIFO interface between a client, its queue and the arbiter.
`timescale 1ns/100ps
`default_nettype none

interface fifo_if;

    // Producer side.
    logic              push;
    mem_pkg::mem_req_t data_in;
    logic              full;

    // Consumer side.
    logic              pop;
    mem_pkg::mem_req_t data_out;
    logic              valid;

    // Client that fills the queue.
    modport producer (output push, output data_in, input full);

    // Arbiter that drains the queue.
    modport consumer (output pop, input valid, input data_out);

    // The queue itself.
    modport structure (
        input  push,
        input  data_in,
        input  pop,
        output full,
        output valid,
        output data_out
    );

endinterface

`default_nettype wire

//--- rtl/mem_bus_if.sv
// Four-phase req/ack bus from the arbiter to the data memory.
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;

    // Master to slave, held stable while req is high.
    logic                            req;
    mem_pkg::mem_op_e                op;
    logic [mem_pkg::ADDR_WIDTH-1:0]  addr;
    logic [mem_pkg::DATA_WIDTH-1:0]  wdata;

    // Slave to master, rdata valid with ack on reads.
    logic                            ack;
    logic [mem_pkg::DATA_WIDTH-1:0]  rdata;

    // Arbiter side.
    modport master (
        output req,
        output op,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    // Memory side.
    modport slave (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

//--- rtl/mem_pkg.sv
// Shared memory package with widths, depths, opcodes, arbiter states and the request word.
`default_nettype none

package mem_pkg;

    // Word address width, 16 words.
    localparam int ADDR_WIDTH = 4;
    // Data word width.
    localparam int DATA_WIDTH = 32;
    // Number of words in the data memory.
    localparam int MEM_WORDS = 1 << ADDR_WIDTH;

    // Requesting clients and the width of a client index.
    localparam int NUM_CLIENTS = 2;
    localparam int CLIENT_WIDTH = $clog2(NUM_CLIENTS);

    // Default request queue depth.
    localparam int FIFO_DEPTH = 4;

    // Memory operation.
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // One queued request, 37 bits.
    typedef struct packed {
        mem_op_e                 op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
    } mem_req_t;

    // Arbiter bus master states.
    typedef enum logic [1:0] {
        arb_idle    = 2'd0,
        arb_req     = 2'd1,
        arb_release = 2'd2
    } arb_state_e;

endpackage

`default_nettype wire

//--- rtl/req_fifo.sv
// Small request queue in LUT RAM, occupancy tracked by a signed in-flight counter.
`timescale 1ns/100ps
`default_nettype none

module req_fifo #(
    parameter int DEPTH = mem_pkg::FIFO_DEPTH
) (
    input logic       clk,
    input logic       rst,
    fifo_if.structure fifo
);

    generate
        if (DEPTH == 1) begin : g_single
            // One entry, the register is the whole queue.
            always_ff @(posedge clk) begin
                if (rst) begin
                    fifo.valid <= 1'b0;
                end else if (fifo.push) begin
                    fifo.valid <= 1'b1;
                end else if (fifo.pop) begin
                    fifo.valid <= 1'b0;
                end
            end

            assign fifo.full = fifo.valid;

            // Payload only, no reset.
            always_ff @(posedge clk) begin
                if (fifo.push) begin
                    fifo.data_out <= fifo.data_in;
                end
            end
        end else begin : g_ram
            mem_pkg::mem_req_t           ram [DEPTH];
            logic [$clog2(DEPTH)-1:0]    wr_idx;
            logic [$clog2(DEPTH)-1:0]    rd_idx;
            logic [$clog2(DEPTH):0]      inflight;

            // Counts down on push and up on pop.
            // Negative means entries are held; -DEPTH means full.
            always_ff @(posedge clk) begin
                if (rst) begin
                    inflight <= '0;
                end else begin
                    inflight <= inflight + ($clog2(DEPTH)+1)'(fifo.pop)
                                         - ($clog2(DEPTH)+1)'(fifo.push);
                end
            end

            // Sign bit says at least one entry.
            assign fifo.valid = inflight[$clog2(DEPTH)];
            assign fifo.full  = fifo.valid & ~|inflight[$clog2(DEPTH)-1:0];

            // Indices wrap naturally at a power-of-two depth.
            always_ff @(posedge clk) begin
                if (rst) begin
                    wr_idx <= '0;
                    rd_idx <= '0;
                end else begin
                    wr_idx <= wr_idx + $clog2(DEPTH)'(fifo.push);
                    rd_idx <= rd_idx + $clog2(DEPTH)'(fifo.pop);
                end
            end

            always_ff @(posedge clk) begin
                if (fifo.push) begin
                    ram[wr_idx] <= fifo.data_in;
                end
            end

            // Head is read straight out of the RAM.
            assign fifo.data_out = ram[rd_idx];
        end
    endgenerate

    // The producer must watch full, unless a pop frees the slot in the same cycle.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(fifo.full && fifo.push && !fifo.pop))
        else $error("req_fifo overflow");

    // The consumer must only pop a valid head.
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        !(fifo.pop && !fifo.valid))
        else $error("req_fifo underflow");

endmodule

`default_nettype wire

//--- rtl/rr_arbiter.sv
// Round-robin client selector and four-phase bus master returning read data to its client.
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    fifo_if.consumer                          fifos [mem_pkg::NUM_CLIENTS],
    mem_bus_if.master                         bus,
    output logic [mem_pkg::NUM_CLIENTS-1:0]   rvalid,
    output logic [mem_pkg::DATA_WIDTH-1:0]    rdata
);

    mem_pkg::arb_state_e                  state;
    logic [mem_pkg::NUM_CLIENTS-1:0]      head_valid;
    mem_pkg::mem_req_t                    head [mem_pkg::NUM_CLIENTS];
    logic [mem_pkg::NUM_CLIENTS-1:0]      pop;
    logic [mem_pkg::CLIENT_WIDTH-1:0]     grant;
    logic                                 grant_found;
    // Owner of the current transaction and round-robin pointer.
    logic [mem_pkg::CLIENT_WIDTH-1:0]     owner;
    mem_pkg::mem_req_t                    cur_req;

    // Flatten the queue ports into plain vectors.
    generate
        for (genvar i = 0; i < mem_pkg::NUM_CLIENTS; i++) begin : g_client
            assign head_valid[i] = fifos[i].valid;
            assign head[i]       = fifos[i].data_out;
            assign fifos[i].pop  = pop[i];
        end
    endgenerate

    // Search starts at the client after the last owner.
    always_comb begin
        int idx;
        grant       = owner;
        grant_found = 1'b0;
        for (int k = 1; k <= mem_pkg::NUM_CLIENTS; k++) begin
            idx = (int'(owner) + k) % mem_pkg::NUM_CLIENTS;
            if (!grant_found && head_valid[idx]) begin
                grant       = idx[mem_pkg::CLIENT_WIDTH-1:0];
                grant_found = 1'b1;
            end
        end
    end

    // Pop the granted head while idle.
    always_comb begin
        pop = '0;
        if (state == mem_pkg::arb_idle && grant_found) begin
            pop[grant] = 1'b1;
        end
    end

    // Control FSM.
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= mem_pkg::arb_idle;
            // Highest client counts as last owner so client 0 wins first.
            owner  <= '1;
            rvalid <= '0;
        end else begin
            rvalid <= '0;
            unique case (state)
                mem_pkg::arb_idle: begin
                    if (grant_found) begin
                        owner <= grant;
                        state <= mem_pkg::arb_req;
                    end
                end
                mem_pkg::arb_req: begin
                    // Drop req and report reads once ack is seen.
                    if (bus.ack) begin
                        state <= mem_pkg::arb_release;
                        if (cur_req.op == mem_pkg::op_read) begin
                            rvalid[owner] <= 1'b1;
                        end
                    end
                end
                mem_pkg::arb_release: begin
                    // Slave must drop ack before the next request.
                    if (!bus.ack) begin
                        state <= mem_pkg::arb_idle;
                    end
                end
                default: state <= mem_pkg::arb_idle;
            endcase
        end
    end

    // Request and read data registers.
    always_ff @(posedge clk) begin
        if (state == mem_pkg::arb_idle && grant_found) begin
            cur_req <= head[grant];
        end
        if (state == mem_pkg::arb_req && bus.ack && cur_req.op == mem_pkg::op_read) begin
            rdata <= bus.rdata;
        end
    end

    // Bus outputs come straight from registers.
    assign bus.req   = (state == mem_pkg::arb_req);
    assign bus.op    = cur_req.op;
    assign bus.addr  = cur_req.addr;
    assign bus.wdata = cur_req.wdata;

    // Ack only rises in answer to a pending request.
    a_ack_on_req: assert property (@(posedge clk) disable iff (rst)
        $rose(bus.ack) |-> bus.req)
        else $error("rr_arbiter saw ack rise without req");

    // Payload holds still for the memory while req stays up.
    a_bus_stable: assert property (@(posedge clk) disable iff (rst)
        bus.req |=> !bus.req || $stable({bus.op, bus.addr, bus.wdata}))
        else $error("rr_arbiter changed bus payload under req");

endmodule

`default_nettype wire

//--- rtl/shared_mem_top.sv
// Two-client shared data memory top with request queues, arbiter and memory.
`timescale 1ns/100ps
`default_nettype none

module shared_mem_top (
    input  logic                            clk,
    input  logic                            rst,
    // Client 0.
    input  logic                            c0_push,
    input  mem_pkg::mem_op_e                c0_op,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  c0_addr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  c0_wdata,
    output logic                            c0_full,
    output logic                            c0_rvalid,
    output logic [mem_pkg::DATA_WIDTH-1:0]  c0_rdata,
    // Client 1.
    input  logic                            c1_push,
    input  mem_pkg::mem_op_e                c1_op,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  c1_addr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  c1_wdata,
    output logic                            c1_full,
    output logic                            c1_rvalid,
    output logic [mem_pkg::DATA_WIDTH-1:0]  c1_rdata
);

    logic [mem_pkg::NUM_CLIENTS-1:0]  arb_rvalid;
    logic [mem_pkg::DATA_WIDTH-1:0]   arb_rdata;

    fifo_if    client_fifo [mem_pkg::NUM_CLIENTS] ();
    mem_bus_if mem_bus ();

    // Client ports onto the producer side of each queue.
    assign client_fifo[0].push    = c0_push;
    assign client_fifo[0].data_in = '{op: c0_op, addr: c0_addr, wdata: c0_wdata};
    assign c0_full                = client_fifo[0].full;

    assign client_fifo[1].push    = c1_push;
    assign client_fifo[1].data_in = '{op: c1_op, addr: c1_addr, wdata: c1_wdata};
    assign c1_full                = client_fifo[1].full;

    req_fifo #(.DEPTH(mem_pkg::FIFO_DEPTH)) u_fifo0 (
        .clk  (clk),
        .rst  (rst),
        .fifo (client_fifo[0])
    );

    req_fifo #(.DEPTH(mem_pkg::FIFO_DEPTH)) u_fifo1 (
        .clk  (clk),
        .rst  (rst),
        .fifo (client_fifo[1])
    );

    rr_arbiter u_arbiter (
        .clk    (clk),
        .rst    (rst),
        .fifos  (client_fifo),
        .bus    (mem_bus),
        .rvalid (arb_rvalid),
        .rdata  (arb_rdata)
    );

    data_memory u_memory (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus)
    );

    // Shared read data, qualified per client by rvalid.
    assign c0_rvalid = arb_rvalid[0];
    assign c1_rvalid = arb_rvalid[1];
    assign c0_rdata  = arb_rdata;
    assign c1_rdata  = arb_rdata;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds and runs shared_mem_tb with Verilator, then searches the log for the fail message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module shared_mem_tb \
    -f sources.f -o shared_mem_sim > build.log 2>&1 ||
    { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/shared_mem_sim > sim.log 2>&1
cat sim.log
! grep -q "Something failed" sim.log && grep -q "Everything OK" sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

//--- sources.f
rtl/mem_pkg.sv
rtl/fifo_if.sv
rtl/mem_bus_if.sv
rtl/req_fifo.sv
rtl/rr_arbiter.sv
rtl/data_memory.sv
rtl/shared_mem_top.sv
verification/shared_mem_tb.sv

//--- verification/shared_mem_tb.sv
// Testbench for the two-client shared memory, table driven against a reference memory model.
`timescale 1ns/100ps
`default_nettype none

module shared_mem_tb;

    // One stimulus row of the table.
    typedef struct {
        int                               test;
        int                               client;
        mem_pkg::mem_op_e                 op;
        logic [mem_pkg::ADDR_WIDTH-1:0]   addr;
        logic [mem_pkg::DATA_WIDTH-1:0]   wdata;
        // Pushed in the same cycle as the next row.
        bit                               together;
        // Wait for every outstanding read after this row.
        bit                               sync;
    } stim_t;

    logic                            clk;
    logic                            rst;
    logic                            c0_push;
    mem_pkg::mem_op_e                c0_op;
    logic [mem_pkg::ADDR_WIDTH-1:0]  c0_addr;
    logic [mem_pkg::DATA_WIDTH-1:0]  c0_wdata;
    logic                            c0_full;
    logic                            c0_rvalid;
    logic [mem_pkg::DATA_WIDTH-1:0]  c0_rdata;
    logic                            c1_push;
    mem_pkg::mem_op_e                c1_op;
    logic [mem_pkg::ADDR_WIDTH-1:0]  c1_addr;
    logic [mem_pkg::DATA_WIDTH-1:0]  c1_wdata;
    logic                            c1_full;
    logic                            c1_rvalid;
    logic [mem_pkg::DATA_WIDTH-1:0]  c1_rdata;

    stim_t                           stim_q [$];
    // Reference memory updated in issue order.
    logic [mem_pkg::DATA_WIDTH-1:0]  ref_mem [mem_pkg::MEM_WORDS];
    // Expected read data per client in push order.
    logic [mem_pkg::DATA_WIDTH-1:0]  exp0_q [$];
    logic [mem_pkg::DATA_WIDTH-1:0]  exp1_q [$];
    // Client of each rvalid pulse in arrival order.
    logic                            owner_q [$];
    logic [31:0]                     lfsr_state = 32'h141d;
    int                              error_count = 0;
    int                              check_count = 0;
    int                              test_count = 0;
    int                              test_start_errors = 0;
    int                              cycle_count = 0;
    int                              cycle_limit = 0;
    string                           test_name [1:5];

    shared_mem_top uut (
        .clk       (clk),
        .rst       (rst),
        .c0_push   (c0_push),
        .c0_op     (c0_op),
        .c0_addr   (c0_addr),
        .c0_wdata  (c0_wdata),
        .c0_full   (c0_full),
        .c0_rvalid (c0_rvalid),
        .c0_rdata  (c0_rdata),
        .c1_push   (c1_push),
        .c1_op     (c1_op),
        .c1_addr   (c1_addr),
        .c1_wdata  (c1_wdata),
        .c1_full   (c1_full),
        .c1_rvalid (c1_rvalid),
        .c1_rdata  (c1_rdata)
    );

    // 100 ns clock.
    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // One LFSR step per data bit.
    function automatic logic [mem_pkg::DATA_WIDTH-1:0] random_word();
        logic [mem_pkg::DATA_WIDTH-1:0] word;
        word = '0;
        for (int b = 0; b < mem_pkg::DATA_WIDTH; b++) begin
            word = {word[mem_pkg::DATA_WIDTH-2:0], next_lfsr_bit()};
        end
        return word;
    endfunction

    task automatic check_data(input string name, input logic [mem_pkg::DATA_WIDTH-1:0] got,
                              input logic [mem_pkg::DATA_WIDTH-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Writes take their data from the LFSR as the row is built.
    task automatic add_entry(input int test, input int client, input mem_pkg::mem_op_e op,
                             input int addr, input bit together, input bit sync);
        stim_t e;
        e.test     = test;
        e.client   = client;
        e.op       = op;
        e.addr     = addr[mem_pkg::ADDR_WIDTH-1:0];
        e.wdata    = (op == mem_pkg::op_write) ? random_word() : '0;
        e.together = together;
        e.sync     = sync;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        // Every word reads zero after reset with both clients pushing at once.
        for (int a = 0; a < 8; a++) begin
            add_entry(1, 0, mem_pkg::op_read, a, 1'b1, 1'b0);
            add_entry(1, 1, mem_pkg::op_read, a + 8, 1'b0, a == 7);
        end
        add_entry(2, 0, mem_pkg::op_write, 5, 1'b0, 1'b0);
        add_entry(2, 0, mem_pkg::op_read, 5, 1'b0, 1'b0);
        add_entry(2, 1, mem_pkg::op_write, 6, 1'b0, 1'b0);
        add_entry(2, 1, mem_pkg::op_read, 6, 1'b0, 1'b1);
        // Enough rows to fill the client 0 queue.
        for (int a = 0; a < 4; a++) begin
            add_entry(3, 0, mem_pkg::op_write, a, 1'b0, 1'b0);
        end
        for (int a = 0; a < 4; a++) begin
            add_entry(3, 0, mem_pkg::op_read, a, 1'b0, a == 3);
        end
        // Client 1 writes and fences so that it owns the last grant.
        add_entry(4, 1, mem_pkg::op_write, 8, 1'b0, 1'b0);
        add_entry(4, 1, mem_pkg::op_write, 9, 1'b0, 1'b0);
        add_entry(4, 1, mem_pkg::op_write, 12, 1'b0, 1'b0);
        add_entry(4, 1, mem_pkg::op_write, 13, 1'b0, 1'b0);
        add_entry(4, 1, mem_pkg::op_read, 13, 1'b0, 1'b1);
        add_entry(4, 0, mem_pkg::op_read, 8, 1'b1, 1'b0);
        add_entry(4, 1, mem_pkg::op_read, 12, 1'b0, 1'b0);
        add_entry(4, 0, mem_pkg::op_read, 9, 1'b1, 1'b0);
        add_entry(4, 1, mem_pkg::op_read, 13, 1'b0, 1'b1);
        // Interleaved writes and a fence read per client come before the cross reads.
        add_entry(5, 0, mem_pkg::op_write, 0, 1'b1, 1'b0);
        add_entry(5, 1, mem_pkg::op_write, 14, 1'b0, 1'b0);
        add_entry(5, 0, mem_pkg::op_write, 1, 1'b1, 1'b0);
        add_entry(5, 1, mem_pkg::op_write, 15, 1'b0, 1'b0);
        add_entry(5, 0, mem_pkg::op_read, 1, 1'b1, 1'b0);
        add_entry(5, 1, mem_pkg::op_read, 15, 1'b0, 1'b1);
        add_entry(5, 0, mem_pkg::op_read, 14, 1'b1, 1'b0);
        add_entry(5, 1, mem_pkg::op_read, 0, 1'b0, 1'b0);
        add_entry(5, 0, mem_pkg::op_read, 15, 1'b1, 1'b0);
        add_entry(5, 1, mem_pkg::op_read, 1, 1'b0, 1'b1);
    endtask

    // Updates the model and drives one client for the coming edge.
    task automatic issue_entry(input stim_t e);
        if (e.op == mem_pkg::op_write) begin
            ref_mem[e.addr] = e.wdata;
        end else if (e.client == 0) begin
            exp0_q.push_back(ref_mem[e.addr]);
        end else begin
            exp1_q.push_back(ref_mem[e.addr]);
        end
        if (e.client == 0) begin
            c0_push  <= 1'b1;
            c0_op    <= e.op;
            c0_addr  <= e.addr;
            c0_wdata <= e.wdata;
        end else begin
            c1_push  <= 1'b1;
            c1_op    <= e.op;
            c1_addr  <= e.addr;
            c1_wdata <= e.wdata;
        end
    endtask

    // Holds off while a target queue is full.
    task automatic wait_room(input bit need0, input bit need1);
        @(negedge clk);
        while ((need0 && c0_full) || (need1 && c1_full)) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        @(posedge clk);
        while (exp0_q.size() != 0 || exp1_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input int test);
        @(negedge clk);
        check_flag("c0_full", c0_full, 1'b0);
        check_flag("c1_full", c1_full, 1'b0);
        // Simultaneous reads come back alternating from client 0.
        if (test == 4) begin
            if (owner_q.size() < 4) begin
                error_count++;
                $display("Fewer than four read responses arrived in test 4");
            end else begin
                for (int k = 0; k < 4; k++) begin
                    check_flag($sformatf("rvalid owner %0d", k),
                               owner_q[owner_q.size() - 4 + k], k[0]);
                end
            end
        end
        test_count++;
        $display("Test %0d, %s: %0d errors", test, test_name[test],
                 error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    // Response monitor.
    always @(negedge clk) begin
        if (!rst && c0_rvalid) begin
            check_flag("c1_rvalid", c1_rvalid, 1'b0);
            if (exp0_q.size() == 0) begin
                error_count++;
                $display("Client 0 got read data with no read outstanding");
            end else begin
                check_data("c0_rdata", c0_rdata, exp0_q.pop_front());
            end
            owner_q.push_back(1'b0);
        end
        if (!rst && c1_rvalid) begin
            if (exp1_q.size() == 0) begin
                error_count++;
                $display("Client 1 got read data with no read outstanding");
            end else begin
                check_data("c1_rdata", c1_rdata, exp1_q.pop_front());
            end
            owner_q.push_back(1'b1);
        end
    end

    // Run limit.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int    i;
        bit    paired;
        stim_t first;
        stim_t second;
        stim_t last;
        clk      = 1'b0;
        rst      = 1'b1;
        c0_push  = 1'b0;
        c0_op    = mem_pkg::op_read;
        c0_addr  = '0;
        c0_wdata = '0;
        c1_push  = 1'b0;
        c1_op    = mem_pkg::op_read;
        c1_addr  = '0;
        c1_wdata = '0;
        foreach (ref_mem[a]) begin
            ref_mem[a] = '0;
        end
        test_name[1] = "reset state and zero reads";
        test_name[2] = "write then read";
        test_name[3] = "queued reads in push order";
        test_name[4] = "simultaneous reads alternate";
        test_name[5] = "cross-client writes and reads";
        build_table();
        // Twelve cycles per row plus reset and the memory clear sweep.
        cycle_limit = 12 * stim_q.size() + 8 + 40;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("c0_full", c0_full, 1'b0);
        check_flag("c1_full", c1_full, 1'b0);
        check_flag("c0_rvalid", c0_rvalid, 1'b0);
        check_flag("c1_rvalid", c1_rvalid, 1'b0);
        i = 0;
        while (i < stim_q.size()) begin
            first  = stim_q[i];
            paired = first.together && (i + 1 < stim_q.size());
            second = paired ? stim_q[i + 1] : first;
            last   = second;
            wait_room(first.client == 0 || second.client == 0,
                      first.client == 1 || second.client == 1);
            @(posedge clk);
            issue_entry(first);
            if (paired) begin
                issue_entry(second);
            end
            // One-cycle push pulse lets full settle before the next push.
            @(posedge clk);
            c0_push <= 1'b0;
            c1_push <= 1'b0;
            i += paired ? 2 : 1;
            if (last.sync || i >= stim_q.size() || stim_q[i].test != last.test) begin
                wait_drain();
            end
            if (i >= stim_q.size() || stim_q[i].test != last.test) begin
                report_test(last.test);
            end
        end
        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
